//--- filelist.f
logic/trigger_reg_pkg.sv
logic/trigger_data_pkg.sv
logic/trigger_cfg_if.sv
logic/trigger_regs.sv
logic/trigger_input.sv
logic/trigger_fsm.sv
logic/trigger_fifo.sv
logic/tlu_trigger_top.sv
testbench/tb_tlu_trigger.sv

//--- run_sim.sh
#!/bin/sh
# builds the trigger core testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_tlu_trigger -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- testbench/tb_tlu_trigger.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the trigger core with random pulses against a model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_tlu_trigger;

    localparam int fifo_depth = 16;
    localparam int num_tests = 6;
    localparam int longest_test = 3000; // pin pulse test with 40 pulses and gaps
    localparam int cycle_limit = num_tests * longest_test + 1000;

    logic        BUS_CLK;
    logic        RST;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_rd;
    logic        bus_wr;
    logic [7:0]  bus_data_out;
    logic [7:0]  trigger;
    logic [7:0]  trigger_veto;
    logic        ext_trigger_enable;
    logic        trigger_acknowledge;
    logic        trigger_accepted_flag;
    logic        trigger_enabled;
    logic [7:0]  trigger_selected;
    logic        fifo_read;
    logic        fifo_empty;
    logic [31:0] fifo_data;

    logic [15:0] lfsr;
    int          errors;
    int          cycles;

    // reference model state
    logic [31:0] model_count;
    logic [31:0] model_words [$];
    int          model_lost;
    logic        model_enable;
    logic [31:0] model_max;

    tlu_trigger_top dut_i (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .BUS_ADD(bus_add),
        .BUS_DATA_IN(bus_data_in),
        .BUS_RD(bus_rd),
        .BUS_WR(bus_wr),
        .BUS_DATA_OUT(bus_data_out),
        .TRIGGER(trigger),
        .TRIGGER_VETO(trigger_veto),
        .EXT_TRIGGER_ENABLE(ext_trigger_enable),
        .TRIGGER_ACKNOWLEDGE(trigger_acknowledge),
        .TRIGGER_ACCEPTED_FLAG(trigger_accepted_flag),
        .TRIGGER_ENABLED(trigger_enabled),
        .TRIGGER_SELECTED(trigger_selected),
        .FIFO_READ(fifo_read),
        .FIFO_EMPTY(fifo_empty),
        .FIFO_DATA(fifo_data)
    );

    always #4 BUS_CLK = ~BUS_CLK;

    // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out)
            lfsr = lfsr ^ 16'hB400;
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    // returns whether the core accepts one trigger edge
    function automatic logic model_trigger(input logic vetoed);
        if (!model_enable || vetoed || (model_max != 0 && model_count >= model_max))
            return 1'b0;
        if (model_words.size() < fifo_depth)
            model_words.push_back({1'b1, model_count[30:0]});
        else if (model_lost < 255)
            model_lost++;
        model_count = model_count + 32'd1;
        return 1'b1;
    endfunction

    task automatic model_clear();
        model_count = '0;
        model_words.delete();
        model_lost = 0;
        model_enable = 1'b0;
        model_max = '0;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge BUS_CLK);
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add <= addr;
        bus_data_in <= data;
        bus_wr <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr <= 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add <= addr;
        bus_rd <= 1'b1;
        @(posedge BUS_CLK);
        bus_rd <= 1'b0;
        @(negedge BUS_CLK); // data out is registered
        data = bus_data_out;
    endtask

    // four bytes lsb first
    task automatic write_word(input logic [15:0] base, input logic [31:0] value);
        for (int i = 0; i < 4; i++)
            bus_write(base + 16'(i), value[8*i +: 8]);
    endtask

    task automatic check_count(input string what);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        bus_read(16'd8, b0); // latches the upper bytes
        bus_read(16'd9, b1);
        bus_read(16'd10, b2);
        bus_read(16'd11, b3);
        if ({b3, b2, b1, b0} !== model_count)
            report_mismatch(what, {b3, b2, b1, b0}, model_count);
    endtask

    task automatic check_lost(input string what);
        logic [7:0] data;
        bus_read(16'd12, data);
        if (data !== 8'(model_lost))
            report_mismatch(what, data, 8'(model_lost));
    endtask

    task automatic soft_reset();
        bus_write(16'd0, 8'h00);
        wait_cycles(2);
        model_clear();
    endtask

    task automatic set_enable();
        bus_write(16'd1, 8'h08);
        model_enable = 1'b1;
    endtask

    task automatic soft_trigger_expect(input logic expected, input string what);
        logic seen;
        bus_write(16'd34, 8'h00);
        seen = 1'b0;
        for (int i = 0; i < 12 && !seen; i++)
        begin
            @(negedge BUS_CLK);
            seen = trigger_accepted_flag;
        end
        wait_cycles(4); // fsm back to idle
        if (seen !== expected)
            report_mismatch(what, seen, expected);
    endtask

    task automatic drain_fifo(input string what);
        logic [31:0] exp;
        int          popped;
        popped = 0;
        @(negedge BUS_CLK);
        while (!fifo_empty && popped < 2 * fifo_depth)
        begin
            if (model_words.size() == 0)
            begin
                errors++;
                $display("error at %0t: %s FIFO holds a word the model does not expect",
                         $time, what);
            end
            else
            begin
                exp = model_words.pop_front();
                if (fifo_data !== exp)
                    report_mismatch(what, fifo_data, exp);
            end
            popped++;
            @(posedge BUS_CLK);
            fifo_read <= 1'b1;
            @(posedge BUS_CLK);
            fifo_read <= 1'b0;
            @(negedge BUS_CLK);
        end
        if (model_words.size() != 0)
        begin
            errors++;
            $display("error at %0t: %s FIFO ran empty with %0d words still expected",
                     $time, what, model_words.size());
        end
    endtask

    task automatic register_readback();
        logic [7:0] exp_reg [0:35];
        logic [7:0] value;
        logic [7:0] data;
        for (int a = 0; a < 36; a++)
        begin
            exp_reg[a] = 8'h00;
            if (a != 0 && (a < 8 || a > 12) && a != 34) // no side effect addresses
            begin
                value = 8'(rand_bits(8));
                bus_write(16'(a), value);
                if (a == 1 || (a >= 13 && a <= 28))
                    exp_reg[a] = value;
            end
        end
        exp_reg[0] = 8'd1; // version
        for (int a = 0; a < 36; a++)
        begin
            if (a < 8 || a > 12)
            begin
                bus_read(16'(a), data);
                if (data !== exp_reg[a])
                    report_mismatch($sformatf("register %0d", a), data, exp_reg[a]);
            end
        end
        // low bits of this out of range address alias the soft reset address
        bus_write(16'h0100, 8'hff);
        bus_read(16'h0100, data);
        if (data !== 8'h00)
            report_mismatch("out of range read", data, 8'h00);
        bus_read(16'd1, data);
        if (data !== exp_reg[1])
            report_mismatch("conf after out of range write", data, exp_reg[1]);
    endtask

    task automatic pin_trigger_pulses();
        logic [7:0] inv;
        logic [7:0] sel;
        logic [7:0] vpins;
        logic [7:0] vsel;
        logic [7:0] hi;
        logic       expected;
        int         flags;
        int         hold;
        soft_reset();
        for (int p = 0; p < 40; p++)
        begin
            // OR kept low while the masks change
            bus_write(16'd13, 8'h00);
            inv = 8'(rand_bits(8));
            bus_write(16'd21, inv);
            trigger <= inv;
            vpins = 8'(rand_bits(8)) & 8'(rand_bits(8)) & 8'(rand_bits(8));
            vsel = 8'(rand_bits(8));
            trigger_veto <= vpins;
            bus_write(16'd17, vsel);
            model_enable = rand_bits(2) != 0;
            bus_write(16'd1, {4'h0, model_enable, 3'h0});
            sel = 8'(rand_bits(8));
            bus_write(16'd13, sel);
            wait_cycles(8 + int'(rand_bits(4)));
            hi = inv ^ 8'(rand_bits(8));
            trigger <= hi;
            expected = 1'b0;
            if (((hi ^ inv) & sel) != 0)
                expected = model_trigger(|(vpins & vsel));
            hold = 8 + int'(rand_bits(4));
            flags = 0;
            for (int i = 0; i < hold; i++)
            begin
                @(negedge BUS_CLK);
                if (trigger_accepted_flag)
                    flags++;
            end
            if (flags != int'(expected))
                report_mismatch($sformatf("accept flags of pulse %0d", p), flags, expected);
            if (trigger_selected !== sel)
                report_mismatch("TRIGGER_SELECTED", trigger_selected, sel);
            @(posedge BUS_CLK);
            trigger <= inv; // pulse ends
        end
        wait_cycles(8);
        check_count("pin trigger count");
        check_lost("pin trigger lost count");
        drain_fifo("pin trigger");
        @(posedge BUS_CLK);
        trigger <= 8'h00;
        trigger_veto <= 8'h00;
    endtask

    task automatic soft_trigger_words();
        logic [31:0] preset;
        soft_reset();
        set_enable();
        preset = {12'h000, 20'(rand_bits(20))};
        write_word(16'd8, preset);
        wait_cycles(2);
        model_count = preset;
        for (int i = 0; i < 10; i++)
            soft_trigger_expect(model_trigger(1'b0), "soft trigger accept");
        check_count("soft trigger count");
        drain_fifo("soft trigger");
    endtask

    task automatic count_limit();
        logic [31:0] preset;
        logic        seen;
        soft_reset();
        preset = {16'h0000, 16'(rand_bits(16))};
        write_word(16'd8, preset);
        model_count = preset;
        model_max = preset + 32'd3 + rand_bits(2);
        write_word(16'd25, model_max);
        set_enable();
        seen = 1'b0;
        for (int i = 0; i < 10 && !seen; i++)
        begin
            @(negedge BUS_CLK);
            seen = trigger_enabled;
        end
        if (!seen)
        begin
            errors++;
            $display("error at %0t: TRIGGER_ENABLED did not rise below the limit", $time);
        end
        for (int i = 0; i < 9; i++)
            soft_trigger_expect(model_trigger(1'b0), "accept near the limit");
        @(negedge BUS_CLK);
        if (trigger_enabled !== 1'b0)
            report_mismatch("TRIGGER_ENABLED at the limit", trigger_enabled, 1'b0);
        check_count("count at the limit");
        drain_fifo("count limit");
    endtask

    task automatic external_ack();
        soft_reset();
        ext_trigger_enable <= 1'b1;
        set_enable();
        for (int r = 0; r < 4; r++)
        begin
            soft_trigger_expect(model_trigger(1'b0), "trigger with external ack");
            soft_trigger_expect(1'b0, "trigger while waiting for ack");
            wait_cycles(1 + int'(rand_bits(4))); // ack latency varies
            trigger_acknowledge <= 1'b1;
            @(posedge BUS_CLK);
            trigger_acknowledge <= 1'b0;
            wait_cycles(3);
        end
        check_count("external ack count");
        drain_fifo("external ack");
        @(posedge BUS_CLK);
        ext_trigger_enable <= 1'b0;
    endtask

    task automatic fifo_overflow();
        soft_reset();
        set_enable();
        for (int i = 0; i < fifo_depth + 5; i++)
            soft_trigger_expect(model_trigger(1'b0), "trigger into full FIFO");
        check_lost("lost count");
        check_count("overflow count");
        drain_fifo("overflow");
    endtask

    initial
    begin
        cycles = 0;
        while (cycles < cycle_limit)
        begin
            @(posedge BUS_CLK);
            cycles++;
        end
        $display("timeout: the run did not end within %0d clock cycles", cycle_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        BUS_CLK = 1'b0;
        RST = 1'b1;
        bus_add = '0;
        bus_data_in = '0;
        bus_rd = 1'b0;
        bus_wr = 1'b0;
        trigger = '0;
        trigger_veto = '0;
        ext_trigger_enable = 1'b0;
        trigger_acknowledge = 1'b0;
        fifo_read = 1'b0;
        lfsr = 16'd44725;
        errors = 0;
        model_clear();
        repeat (5) @(posedge BUS_CLK);
        RST <= 1'b0;
        @(negedge BUS_CLK);
        if (bus_data_out !== 8'h00 || trigger_accepted_flag !== 1'b0 ||
            trigger_enabled !== 1'b0 || fifo_empty !== 1'b1)
        begin
            errors++;
            $display("error at %0t: outputs are not at their reset values", $time);
        end
        register_readback();
        pin_trigger_pulses();
        soft_trigger_words();
        count_limit();
        external_ack();
        fifo_overflow();
        $display("%0d errors in %0d cycles", errors, cycles);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/tlu_trigger_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trigger slave core top, single clock, plain bus ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tlu_trigger_top #(
    parameter int ABUSWIDTH = 16,
    parameter int WIDTH = 8,     // trigger and veto pins
    parameter int FIFO_DEPTH = 16
) (
    input  wire                      BUS_CLK,
    input  wire                      RST,
    input  wire [ABUSWIDTH-1:0]      BUS_ADD,
    input  wire [7:0]                BUS_DATA_IN,
    input  wire                      BUS_RD,
    input  wire                      BUS_WR,
    output logic [7:0]               BUS_DATA_OUT,
    input  wire [WIDTH-1:0]          TRIGGER,
    input  wire [WIDTH-1:0]          TRIGGER_VETO,
    input  wire                      EXT_TRIGGER_ENABLE,
    input  wire                      TRIGGER_ACKNOWLEDGE,
    output logic                     TRIGGER_ACCEPTED_FLAG,
    output logic                     TRIGGER_ENABLED,
    output logic [WIDTH-1:0]         TRIGGER_SELECTED,
    input  wire                      FIFO_READ,
    output logic                     FIFO_EMPTY,
    output trigger_data_pkg::word_t  FIFO_DATA
);

    logic                    trg_rise;
    logic                    trg_level;
    logic                    veto;
    logic                    accept;
    trigger_data_pkg::word_t accept_word;

    trigger_cfg_if #(.WIDTH(WIDTH)) cfg_if ();

    assign TRIGGER_SELECTED = cfg_if.trg_select;

    trigger_regs #(
        .ABUSWIDTH(ABUSWIDTH),
        .WIDTH(WIDTH)
    ) regs_i (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .BUS_ADD(BUS_ADD),
        .BUS_DATA_IN(BUS_DATA_IN),
        .BUS_RD(BUS_RD),
        .BUS_WR(BUS_WR),
        .BUS_DATA_OUT(BUS_DATA_OUT),
        .cfg(cfg_if.regs_mp)
    );

    trigger_input #(.WIDTH(WIDTH)) input_i (
        .BUS_CLK(BUS_CLK),
        .TRIGGER(TRIGGER),
        .TRIGGER_VETO(TRIGGER_VETO),
        .cfg(cfg_if.input_mp),
        .trg_rise(trg_rise),
        .trg_level(trg_level),
        .veto(veto)
    );

    trigger_fsm fsm_i (
        .BUS_CLK(BUS_CLK),
        .cfg(cfg_if.fsm_mp),
        .trg_rise(trg_rise),
        .trg_level(trg_level),
        .veto(veto),
        .EXT_TRIGGER_ENABLE(EXT_TRIGGER_ENABLE),
        .TRIGGER_ACKNOWLEDGE(TRIGGER_ACKNOWLEDGE),
        .TRIGGER_ACCEPTED_FLAG(TRIGGER_ACCEPTED_FLAG),
        .TRIGGER_ENABLED(TRIGGER_ENABLED),
        .accept(accept),
        .accept_word(accept_word)
    );

    trigger_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
        .BUS_CLK(BUS_CLK),
        .cfg(cfg_if.fifo_mp),
        .accept(accept),
        .accept_word(accept_word),
        .FIFO_READ(FIFO_READ),
        .FIFO_EMPTY(FIFO_EMPTY),
        .FIFO_DATA(FIFO_DATA)
    );

endmodule

`default_nettype wire

//--- logic/trigger_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trigger word FIFO, full drops are counted as lost data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module trigger_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire                      BUS_CLK,
    trigger_cfg_if.fifo_mp           cfg,
    input  wire                      accept,
    input  wire trigger_data_pkg::word_t accept_word,
    input  wire                      FIFO_READ,
    output logic                     FIFO_EMPTY,
    output trigger_data_pkg::word_t  FIFO_DATA
);

    localparam int AW = $clog2(FIFO_DEPTH);

    trigger_data_pkg::word_t mem [FIFO_DEPTH];
    logic [AW:0]             wr_ptr_q; // extra msb tells full from empty
    logic [AW:0]             rd_ptr_q;
    logic                    full;
    logic                    push;
    logic                    pop;
    trigger_data_pkg::lost_t lost_q;

    assign FIFO_EMPTY = wr_ptr_q == rd_ptr_q;
    assign full = wr_ptr_q[AW] != rd_ptr_q[AW] && wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0];
    assign push = accept && !full;
    assign pop = FIFO_READ && !FIFO_EMPTY;

    always_ff @(posedge BUS_CLK)
    begin
        if (push)
            mem[wr_ptr_q[AW-1:0]] <= accept_word;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (cfg.core_rst)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            lost_q <= '0;
        end
        else
        begin
            if (push)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            if (accept && full && lost_q != '1)
                lost_q <= lost_q + 8'd1; // stops at 255
        end
    end

    assign FIFO_DATA = mem[rd_ptr_q[AW-1:0]]; // head word, valid while not empty
    assign cfg.lost_count = lost_q;

    // reader must check FIFO_EMPTY before popping
    no_pop_empty: assert property (@(posedge BUS_CLK) disable iff (cfg.core_rst)
        FIFO_READ |-> !FIFO_EMPTY);

endmodule

`default_nettype wire

//--- logic/trigger_fsm.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trigger accept FSM with counter, preset and count limit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module trigger_fsm (
    input  wire                      BUS_CLK,
    trigger_cfg_if.fsm_mp            cfg,
    input  wire                      trg_rise,
    input  wire                      trg_level,
    input  wire                      veto,
    input  wire                      EXT_TRIGGER_ENABLE,
    input  wire                      TRIGGER_ACKNOWLEDGE,
    output logic                     TRIGGER_ACCEPTED_FLAG,
    output logic                     TRIGGER_ENABLED,
    output logic                     accept,
    output trigger_data_pkg::word_t  accept_word
);

    trigger_data_pkg::fsm_state_e state_q;
    trigger_data_pkg::count_t     count_q;
    logic                         limit_q;
    logic                         ack;
    logic                         can_accept;

    // without external ack the wait state lasts one cycle
    assign ack = EXT_TRIGGER_ENABLE ? TRIGGER_ACKNOWLEDGE : 1'b1;
    assign can_accept = cfg.enable && !limit_q && !veto;

    always_ff @(posedge BUS_CLK)
    begin
        if (cfg.core_rst)
            state_q <= trigger_data_pkg::idle;
        else
        begin
            case (state_q)
                trigger_data_pkg::idle:
                    if (trg_rise && can_accept)
                        state_q <= trigger_data_pkg::accept;
                trigger_data_pkg::accept:
                    state_q <= trigger_data_pkg::wait_ack;
                trigger_data_pkg::wait_ack:
                    if (ack)
                        state_q <= trigger_data_pkg::wait_low;
                default:
                    if (!trg_level) // trigger must drop before the next one
                        state_q <= trigger_data_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (cfg.core_rst)
            count_q <= '0;
        else if (cfg.cnt_set)
            count_q <= cfg.cnt_set_value;
        else if (state_q == trigger_data_pkg::accept)
            count_q <= count_q + 32'd1;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (cfg.core_rst)
        begin
            limit_q <= 1'b0;
            TRIGGER_ENABLED <= 1'b0;
        end
        else
        begin
            limit_q <= cfg.cnt_max != '0 && count_q >= cfg.cnt_max;
            if (cfg.enable && !limit_q)
                TRIGGER_ENABLED <= 1'b1;
            else if (state_q == trigger_data_pkg::idle)
                TRIGGER_ENABLED <= 1'b0; // drop only between triggers
        end
    end

    assign accept = state_q == trigger_data_pkg::accept;
    assign TRIGGER_ACCEPTED_FLAG = accept;
    assign accept_word = '{id: trigger_data_pkg::word_id, count: count_q[30:0]};
    assign cfg.trigger_count = count_q;

    // the fifo sees at most one word per trigger cycle
    single_accept: assert property (@(posedge BUS_CLK) disable iff (cfg.core_rst)
        accept |=> !accept);

endmodule

`default_nettype wire

//--- logic/trigger_input.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pin synchronizer, trigger select/invert OR, veto OR
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module trigger_input #(
    parameter int WIDTH = 8
) (
    input  wire              BUS_CLK,
    input  wire [WIDTH-1:0]  TRIGGER,
    input  wire [WIDTH-1:0]  TRIGGER_VETO,
    trigger_cfg_if.input_mp  cfg,
    output logic             trg_rise,
    output logic             trg_level,
    output logic             veto
);

    logic [2*WIDTH-1:0] meta_q;  // first stage, {veto, trigger}
    logic [2*WIDTH-1:0] sync_q;
    logic               trg_or;
    logic               level_d; // trg_level one cycle later

    // two stages for the asynchronous pins
    always_ff @(posedge BUS_CLK)
    begin
        if (cfg.core_rst)
        begin
            meta_q <= '0;
            sync_q <= '0;
        end
        else
        begin
            meta_q <= {TRIGGER_VETO, TRIGGER};
            sync_q <= meta_q;
        end
    end

    // invert first, then select
    assign trg_or = |((sync_q[WIDTH-1:0] ^ cfg.trg_invert) & cfg.trg_select) | cfg.soft_trg;

    always_ff @(posedge BUS_CLK)
    begin
        if (cfg.core_rst)
        begin
            trg_level <= 1'b0;
            level_d <= 1'b0;
            veto <= 1'b0;
        end
        else
        begin
            trg_level <= trg_or;
            level_d <= trg_level;
            veto <= |(sync_q[2*WIDTH-1:WIDTH] & cfg.veto_select);
        end
    end

    assign trg_rise = trg_level & ~level_d;

endmodule

`default_nettype wire

//--- logic/trigger_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte register file on the bus, soft reset/trigger strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module trigger_regs #(
    parameter int ABUSWIDTH = 16,
    parameter int WIDTH = 8
) (
    input  wire                 BUS_CLK,
    input  wire                 RST,
    input  wire [ABUSWIDTH-1:0] BUS_ADD,
    input  wire [7:0]           BUS_DATA_IN,
    input  wire                 BUS_RD,
    input  wire                 BUS_WR,
    output logic [7:0]          BUS_DATA_OUT,
    trigger_cfg_if.regs_mp      cfg
);

    logic [trigger_reg_pkg::reg_count-1:0][7:0] regs_q;
    logic [5:0]                 addr;
    logic                       in_range;
    logic                       soft_rst_q;
    logic                       soft_trg_q;
    logic                       cnt_set_q;
    trigger_data_pkg::count_t   cnt_set_value_q;
    logic [23:0]                cnt_buf_q;     // count bits 31..8 held for reads of 9..11
    logic [7:0]                 rd_data;
    logic [31:0]                trg_select_w;
    logic [31:0]                veto_select_w;
    logic [31:0]                trg_invert_w;

    assign addr = BUS_ADD[5:0];
    assign in_range = BUS_ADD < ABUSWIDTH'(trigger_reg_pkg::reg_count);

    // strobes act in the cycle after the write
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            soft_rst_q <= 1'b0;
            soft_trg_q <= 1'b0;
            cnt_set_q <= 1'b0;
        end
        else
        begin
            soft_rst_q <= BUS_WR && in_range && addr == trigger_reg_pkg::addr_soft_rst;
            soft_trg_q <= BUS_WR && in_range && addr == trigger_reg_pkg::addr_soft_trg;
            cnt_set_q <= BUS_WR && in_range && addr == trigger_reg_pkg::addr_cnt3;
        end
    end

    // preset value: written top byte plus the stored bytes 8..10
    always_ff @(posedge BUS_CLK)
    begin
        if (BUS_WR && in_range && addr == trigger_reg_pkg::addr_cnt3)
            cnt_set_value_q <= {BUS_DATA_IN, regs_q[trigger_reg_pkg::addr_cnt0 +: 3]};
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (cfg.core_rst)
            regs_q <= {trigger_reg_pkg::reg_count{trigger_reg_pkg::byte_reset}};
        else if (BUS_WR && in_range)
            regs_q[addr] <= BUS_DATA_IN;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (cfg.core_rst)
            cnt_buf_q <= '0;
        else if (BUS_RD && in_range && addr == trigger_reg_pkg::addr_cnt0)
            cnt_buf_q <= cfg.trigger_count[31:8];
    end

    always_comb
    begin
        rd_data = 8'h00; // unmapped addresses
        if (in_range)
        begin
            case (addr)
                trigger_reg_pkg::addr_soft_rst: rd_data = trigger_reg_pkg::version;
                trigger_reg_pkg::addr_cnt0:     rd_data = cfg.trigger_count[7:0];
                trigger_reg_pkg::addr_cnt1:     rd_data = cnt_buf_q[7:0];
                trigger_reg_pkg::addr_cnt2:     rd_data = cnt_buf_q[15:8];
                trigger_reg_pkg::addr_cnt3:     rd_data = cnt_buf_q[23:16];
                trigger_reg_pkg::addr_lost:     rd_data = cfg.lost_count;
                default:
                begin
                    // conf and the select/veto/invert/max block read back as stored
                    if (addr == trigger_reg_pkg::addr_conf ||
                        (addr >= trigger_reg_pkg::addr_trg_select &&
                         addr <= trigger_reg_pkg::addr_cnt_max3))
                        rd_data = regs_q[addr];
                end
            endcase
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            BUS_DATA_OUT <= 8'h00;
        else if (BUS_RD)
            BUS_DATA_OUT <= rd_data; // held until the next read
    end

    assign trg_select_w = regs_q[trigger_reg_pkg::addr_trg_select +: 4];
    assign veto_select_w = regs_q[trigger_reg_pkg::addr_veto_select +: 4];
    assign trg_invert_w = regs_q[trigger_reg_pkg::addr_trg_invert +: 4];

    assign cfg.core_rst = RST | soft_rst_q;
    assign cfg.enable = regs_q[trigger_reg_pkg::addr_conf][trigger_reg_pkg::conf_enable_bit];
    assign cfg.trg_select = trg_select_w[WIDTH-1:0];
    assign cfg.veto_select = veto_select_w[WIDTH-1:0];
    assign cfg.trg_invert = trg_invert_w[WIDTH-1:0];
    assign cfg.cnt_max = regs_q[trigger_reg_pkg::addr_cnt_max0 +: 4];
    assign cfg.soft_trg = soft_trg_q;
    assign cfg.cnt_set = cnt_set_q;
    assign cfg.cnt_set_value = cnt_set_value_q;

    // the bus master never reads and writes at once
    rd_wr_exclusive: assert property (@(posedge BUS_CLK) disable iff (RST)
        !(BUS_RD && BUS_WR));

endmodule

`default_nettype wire

//--- logic/trigger_cfg_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// configuration out of the register block, status back in
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface trigger_cfg_if #(
    parameter int WIDTH = 8
);
    logic                     core_rst;    // bus reset or soft reset
    logic                     enable;
    logic [WIDTH-1:0]         trg_select;
    logic [WIDTH-1:0]         veto_select;
    logic [WIDTH-1:0]         trg_invert;
    trigger_data_pkg::count_t cnt_max;     // 0 means no limit
    logic                     soft_trg;    // one cycle pulse
    logic                     cnt_set;     // one cycle pulse
    trigger_data_pkg::count_t cnt_set_value;
    trigger_data_pkg::count_t trigger_count;
    trigger_data_pkg::lost_t  lost_count;

    modport regs_mp (
        output core_rst, enable, trg_select, veto_select, trg_invert,
        output cnt_max, soft_trg, cnt_set, cnt_set_value,
        input  trigger_count, lost_count
    );
    modport input_mp (input core_rst, trg_select, veto_select, trg_invert, soft_trg);
    modport fsm_mp (input core_rst, enable, cnt_max, cnt_set, cnt_set_value, output trigger_count);
    modport fifo_mp (input core_rst, output lost_count);
endinterface

`default_nettype wire

//--- logic/trigger_data_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trigger data types: counters, fifo word, fsm states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package trigger_data_pkg;

    typedef logic [31:0] count_t;
    typedef logic [7:0] lost_t; // saturates at 255

    // one fifo word per accepted trigger
    typedef struct packed {
        logic        id;    // always set
        logic [30:0] count; // count before the increment
    } word_t;

    localparam logic word_id = 1'b1;

    typedef enum logic [1:0] {
        idle     = 2'd0,
        accept   = 2'd1,
        wait_ack = 2'd2,
        wait_low = 2'd3
    } fsm_state_e;

endpackage

`default_nettype wire

//--- logic/trigger_reg_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register map of the trigger slave bus interface
// shared by the register block and the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package trigger_reg_pkg;

    // byte addresses on the 8-bit register bus
    typedef enum logic [5:0] {
        addr_soft_rst    = 6'd0,  // write resets core, read gives version
        addr_conf        = 6'd1,
        addr_cnt0        = 6'd8,  // read latches upper count bytes
        addr_cnt1        = 6'd9,
        addr_cnt2        = 6'd10,
        addr_cnt3        = 6'd11, // write loads the counter
        addr_lost        = 6'd12,
        addr_trg_select  = 6'd13, // 4 bytes, lsb first
        addr_veto_select = 6'd17,
        addr_trg_invert  = 6'd21,
        addr_cnt_max0    = 6'd25,
        addr_cnt_max1    = 6'd26,
        addr_cnt_max2    = 6'd27,
        addr_cnt_max3    = 6'd28,
        addr_soft_trg    = 6'd34
    } reg_addr_e;

    localparam int reg_count = 36;             // decoded address range 0..35
    localparam logic [7:0] byte_reset = 8'h00; // every stored byte clears to this
    localparam logic [7:0] version = 8'd1;
    localparam int conf_enable_bit = 3;

endpackage

`default_nettype wire
